// ==== design/exec_unit.sv ====
module exec_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mips_pkg::data_width-1:0] instr,
    input  logic                            instr_valid,
    output logic                            retire,
    output logic                            jump,
    output logic [mips_pkg::data_width-1:0] jump_target,
    output logic                            mem_start,
    output logic                            mem_write,
    output logic [mips_pkg::data_width-1:0] mem_addr_in,
    output logic [mips_pkg::data_width-1:0] mem_wdata_in,
    input  logic                            mem_done,
    input  logic [mips_pkg::data_width-1:0] mem_rdata_out
);

    mips_pkg::core_state_t state;
    mips_pkg::alu_op_t     alu_op;

    // instruction fields
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;

    // decode flags
    logic is_rtype;
    logic is_alu_r;
    logic is_lw;
    logic is_sw;
    logic is_addiu;
    logic is_jr;
    logic is_mem;
    logic is_legal;
    logic writes_reg;
    logic [4:0] dest;

    // datapath
    logic [mips_pkg::data_width-1:0] imm_sext;
    logic [mips_pkg::data_width-1:0] rs_data;
    logic [mips_pkg::data_width-1:0] rt_data;
    logic [mips_pkg::data_width-1:0] alu_b;
    logic [mips_pkg::data_width-1:0] alu_out;
    logic [mips_pkg::data_width-1:0] result;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    assign is_rtype = (opcode == mips_pkg::op_rtype);
    assign is_alu_r = is_rtype && ((funct == mips_pkg::fn_and) ||
                                   (funct == mips_pkg::fn_addu) ||
                                   (funct == mips_pkg::fn_subu));
    assign is_jr    = is_rtype && (funct == mips_pkg::fn_jr);
    assign is_lw    = (opcode == mips_pkg::op_lw);
    assign is_sw    = (opcode == mips_pkg::op_sw);
    assign is_addiu = (opcode == mips_pkg::op_addiu);
    assign is_mem   = is_lw || is_sw;
    assign is_legal = is_alu_r || is_jr || is_mem || is_addiu;

    // rd for r-type, rt for lw and addiu
    assign writes_reg = is_alu_r || is_lw || is_addiu;
    assign dest       = is_rtype ? rd : rt;

    // sign extension shared by addresses and addiu
    assign imm_sext = {{(mips_pkg::data_width-16){imm[15]}}, imm};
    assign alu_b    = is_alu_r ? rt_data : imm_sext;

    always_comb begin
        alu_op = mips_pkg::alu_add;
        if (is_alu_r && (funct == mips_pkg::fn_and)) begin
            alu_op = mips_pkg::alu_and;
        end else if (is_alu_r && (funct == mips_pkg::fn_subu)) begin
            alu_op = mips_pkg::alu_sub;
        end
    end

    always_comb begin
        case (alu_op)
            mips_pkg::alu_sub: alu_out = rs_data - alu_b;
            mips_pkg::alu_and: alu_out = rs_data & alu_b;
            default:           alu_out = rs_data + alu_b;
        endcase
    end

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      ((state == mips_pkg::st_wb) && writes_reg),
        .wr_addr (dest),
        .wr_data (result)
    );

    // bus request issued from exec, fields sampled by mem_port
    assign mem_start    = (state == mips_pkg::st_exec) && is_mem;
    assign mem_write    = is_sw;
    assign mem_addr_in  = alu_out;
    assign mem_wdata_in = rt_data;

    // retire in wb, jr carries its target along
    assign retire      = (state == mips_pkg::st_wb);
    assign jump        = retire && is_jr;
    assign jump_target = rs_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mips_pkg::st_fetch;
        end else begin
            case (state)
                mips_pkg::st_fetch: begin
                    if (instr_valid) begin
                        state <= is_legal ? mips_pkg::st_exec : mips_pkg::st_halt;
                    end
                end
                mips_pkg::st_exec: state <= is_mem ? mips_pkg::st_mem : mips_pkg::st_wb;
                mips_pkg::st_mem: begin
                    if (mem_done) begin
                        state <= mips_pkg::st_wb;
                    end
                end
                mips_pkg::st_wb:   state <= mips_pkg::st_fetch;
                mips_pkg::st_halt: state <= mips_pkg::st_halt;
                default:           state <= mips_pkg::st_fetch;
            endcase
        end
    end

    // writeback value, alu result or load data
    always_ff @(posedge clk) begin
        if (state == mips_pkg::st_exec) begin
            result <= alu_out;
        end else if ((state == mips_pkg::st_mem) && mem_done) begin
            result <= mem_rdata_out;
        end
    end

endmodule

// ==== design/fetch_unit.sv ====
module fetch_unit (
    input  logic                            clk,
    input  logic                            rst,
    output logic [mips_pkg::data_width-1:0] instr,
    output logic                            instr_valid,
    input  logic                            retire,
    input  logic                            jump,
    input  logic [mips_pkg::data_width-1:0] jump_target,
    output logic                            halted
);

    // address of the next instruction to fetch
    logic [mips_pkg::data_width-1:0] pc;
    // address presented to the instruction memory
    logic [mips_pkg::data_width-1:0] fetch_pc;
    logic [mips_pkg::data_width-1:0] ram_instr;

    // first fetch after reset release
    logic boot;
    // jr retired, waiting for its delay slot to retire
    logic jump_pend;
    logic [mips_pkg::data_width-1:0] jump_pc;

    logic fetch_go;
    logic stop;

    instr_ram u_instr_ram (
        .pc    (fetch_pc),
        .instr (ram_instr)
    );

    // once the delay slot is done the pending target replaces pc
    assign fetch_pc = jump_pend ? jump_pc : pc;

    // jump to address 0 with its delay slot retired, program is over
    assign stop = retire && jump_pend && (jump_pc == '0);

    assign fetch_go = !halted && (boot || (retire && !stop));

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= mips_pkg::reset_vector;
            boot        <= 1'b1;
            jump_pend   <= 1'b0;
            instr_valid <= 1'b0;
            halted      <= 1'b0;
        end else begin
            boot        <= 1'b0;
            instr_valid <= fetch_go;
            if (fetch_go) begin
                pc <= fetch_pc + 32'd4;
            end
            if (stop) begin
                halted <= 1'b1;
            end
            if (retire) begin
                // delay slot retiring consumes the pending jump
                if (jump_pend) begin
                    jump_pend <= 1'b0;
                end else if (jump) begin
                    jump_pend <= 1'b1;
                end
            end
        end
    end

    // instruction register and jump target
    always_ff @(posedge clk) begin
        if (fetch_go) begin
            instr <= ram_instr;
        end
        if (retire && jump && !jump_pend) begin
            jump_pc <= jump_target;
        end
    end

endmodule

// ==== design/instr_ram.sv ====
module instr_ram (
    input  logic [mips_pkg::data_width-1:0] pc,
    output logic [mips_pkg::data_width-1:0] instr
);

    // program storage, one instruction per entry
    logic [mips_pkg::data_width-1:0] rom [0:mips_pkg::iram_words-1];

    // byte offset from the boot address
    logic [mips_pkg::data_width-1:0] offset;
    logic [$clog2(mips_pkg::iram_words)-1:0] word_idx;

    // r-type word, opcode is always zero
    function automatic logic [31:0] r_word(
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [4:0] rd,
        input logic [4:0] shamt,
        input logic [5:0] funct
    );
        r_word = {mips_pkg::op_rtype, rs, rt, rd, shamt, funct};
    endfunction

    // i-type word with a 16-bit immediate
    function automatic logic [31:0] i_word(
        input logic [5:0]  opcode,
        input logic [4:0]  rs,
        input logic [4:0]  rt,
        input logic [15:0] imm
    );
        i_word = {opcode, rs, rt, imm};
    endfunction

    // build the fixed program at elaboration
    initial begin
        logic [31:0] waddr;
        int k;
        waddr = '0;
        // lw r2..r16 from data words 0x0..0x38, base r0
        for (k = 2; k <= 16; k++) begin
            rom[waddr >> 2] = i_word(mips_pkg::op_lw, 5'd0, 5'(k), 16'((k - 2) * 4));
            waddr += 4;
        end
        // and of neighbouring loaded registers into r17..r30
        for (k = 3; k <= 16; k++) begin
            rom[waddr >> 2] = r_word(5'(k - 1), 5'(k), 5'(k + 14), 5'd0, mips_pkg::fn_and);
            waddr += 4;
        end
        // sw r17..r30 to 0x100..0x134
        for (k = 17; k <= 30; k++) begin
            rom[waddr >> 2] = i_word(mips_pkg::op_sw, 5'd0, 5'(k), 16'(16'h100 + (k - 17) * 4));
            waddr += 4;
        end
        // jr r0, target zero ends the run
        rom[waddr >> 2] = r_word(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr);
        waddr += 4;
        // delay slot filler, clears r2
        rom[waddr >> 2] = i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'h0000);
    end

    // fold the boot address onto entry 0
    assign offset = pc % mips_pkg::reset_vector;

    // word index, low two bits dropped
    assign word_idx = offset[$clog2(mips_pkg::iram_words)+1:2];

    assign instr = rom[word_idx];

endmodule

// ==== design/mem_port.sv ====
module mem_port (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mem_start,
    input  logic                            mem_write,
    input  logic [mips_pkg::data_width-1:0] mem_addr_in,
    input  logic [mips_pkg::data_width-1:0] mem_wdata_in,
    output logic                            mem_done,
    output logic [mips_pkg::data_width-1:0] mem_rdata_out,
    output logic                            mem_req,
    input  logic                            mem_ack,
    output logic                            mem_we,
    output logic [mips_pkg::data_width-1:0] mem_addr,
    output logic [mips_pkg::data_width-1:0] mem_wdata,
    input  logic [mips_pkg::data_width-1:0] mem_rdata
);

    // four-phase requester states
    typedef enum logic [1:0] {
        mp_idle    = 2'd0,
        mp_wait_hi = 2'd1,
        mp_wait_lo = 2'd2
    } mp_state_t;

    mp_state_t state;
    logic      issue;

    // new request only from idle, ack already seen low
    assign issue = (state == mp_idle) && mem_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= mp_idle;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state)
                mp_idle: begin
                    if (issue) begin
                        mem_req <= 1'b1;
                        mem_we  <= mem_write;
                        state   <= mp_wait_hi;
                    end
                end
                mp_wait_hi: begin
                    // slave took the request, release it
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= mp_wait_lo;
                    end
                end
                mp_wait_lo: begin
                    // handshake closed once ack drops
                    if (!mem_ack) begin
                        mem_done <= 1'b1;
                        state    <= mp_idle;
                    end
                end
                default: state <= mp_idle;
            endcase
        end
    end

    // address and write data held stable for the whole request
    always_ff @(posedge clk) begin
        if (issue) begin
            mem_addr  <= mem_addr_in;
            mem_wdata <= mem_wdata_in;
        end
        // read data only valid while ack is high
        if ((state == mp_wait_hi) && mem_ack) begin
            mem_rdata_out <= mem_rdata;
        end
    end

endmodule

// ==== design/mips_pkg.sv ====
package mips_pkg;

    // width of every data word, address and register
    localparam int data_width = 32;

    // kseg1 boot address, first fetch after reset
    localparam logic [data_width-1:0] reset_vector = 32'hbfc0_0000;

    // depth of the instruction memory in words
    localparam int iram_words = 4096;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] op_rtype = 6'b000000;
    localparam logic [5:0] op_lw    = 6'b100011;
    localparam logic [5:0] op_sw    = 6'b101011;
    localparam logic [5:0] op_addiu = 6'b001001;

    // funct codes for the r-type group, instr[5:0]
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_jr   = 6'b001000;

    // alu operations
    // loads, stores and addiu all use the adder
    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2
    } alu_op_t;

    // core sequencing states
    // one instruction moves through these at a time
    typedef enum logic [2:0] {
        // waiting for the next instruction from fetch
        st_fetch = 3'd0,
        // operands read, alu result or address formed
        st_exec  = 3'd1,
        // bus access in progress
        st_mem   = 3'd2,
        // register write and retire
        st_wb    = 3'd3,
        // parked on an encoding the core does not run
        st_halt  = 3'd4
    } core_state_t;

endpackage

// ==== design/mips_top.sv ====
module mips_top (
    input  logic                            clk,
    input  logic                            rst,
    output logic                            mem_req,
    input  logic                            mem_ack,
    output logic                            mem_we,
    output logic [mips_pkg::data_width-1:0] mem_addr,
    output logic [mips_pkg::data_width-1:0] mem_wdata,
    input  logic [mips_pkg::data_width-1:0] mem_rdata,
    output logic                            halted
);

    // fetch to execute
    logic [mips_pkg::data_width-1:0] instr;
    logic                            instr_valid;
    logic                            retire;
    logic                            jump;
    logic [mips_pkg::data_width-1:0] jump_target;

    // execute to memory port
    logic                            mem_start;
    logic                            mem_write;
    logic [mips_pkg::data_width-1:0] mem_addr_in;
    logic [mips_pkg::data_width-1:0] mem_wdata_in;
    logic                            mem_done;
    logic [mips_pkg::data_width-1:0] mem_rdata_out;

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .retire      (retire),
        .jump        (jump),
        .jump_target (jump_target),
        .halted      (halted)
    );

    exec_unit u_exec_unit (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .retire        (retire),
        .jump          (jump),
        .jump_target   (jump_target),
        .mem_start     (mem_start),
        .mem_write     (mem_write),
        .mem_addr_in   (mem_addr_in),
        .mem_wdata_in  (mem_wdata_in),
        .mem_done      (mem_done),
        .mem_rdata_out (mem_rdata_out)
    );

    // data bus master towards external memory
    mem_port u_mem_port (
        .clk           (clk),
        .rst           (rst),
        .mem_start     (mem_start),
        .mem_write     (mem_write),
        .mem_addr_in   (mem_addr_in),
        .mem_wdata_in  (mem_wdata_in),
        .mem_done      (mem_done),
        .mem_rdata_out (mem_rdata_out),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata)
    );

endmodule

// ==== design/reg_file.sv ====
module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [4:0]                      rs_addr,
    input  logic [4:0]                      rt_addr,
    output logic [mips_pkg::data_width-1:0] rs_data,
    output logic [mips_pkg::data_width-1:0] rt_data,
    input  logic                            we,
    input  logic [4:0]                      wr_addr,
    input  logic [mips_pkg::data_width-1:0] wr_data
);

    // general purpose registers r0..r31
    logic [mips_pkg::data_width-1:0] regs [0:31];

    // asynchronous read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            // every run starts from a clean register set
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != 5'd0)) begin
            // r0 is never written, reads back as zero
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== files.f ====
design/mips_pkg.sv
design/instr_ram.sv
design/fetch_unit.sv
design/reg_file.sv
design/exec_unit.sv
design/mem_port.sv
design/mips_top.sv
testbench/tb_clock.sv
testbench/tb_data_mem.sv
testbench/tb_mips.sv

// ==== run.sh ====
#!/bin/sh
# build and run the MIPS core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mips -f files.f -o Vtb_mips

./obj_dir/Vtb_mips > sim.log
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== testbench/tb_clock.sv ====
module tb_clock (
    output logic clk
);

    // half period of 2, full period of 4
    localparam int half_period = 2;

    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule

// ==== testbench/tb_data_mem.sv ====
module tb_data_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    output logic        mem_ack,
    input  logic        mem_we,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata
);

    // word storage, covers 0x000..0x1fc
    logic [31:0] words [0:127];

    // one entry per transaction, in bus order
    logic        log_we[$];
    logic [31:0] log_addr[$];
    logic [31:0] log_data[$];

    // shared by preload values and ack delays
    int seed = 32'he0df_9d18;
    // requests that were never released by the master
    int stuck_count = 0;

    // fresh random contents and an empty log for the next run
    task automatic preload();
        int k;
        for (k = 0; k < 128; k++) begin
            words[k] = $random(seed);
        end
        log_we.delete();
        log_addr.delete();
        log_data.delete();
    endtask

    // complete the data phase and raise ack
    task automatic serve();
        logic [6:0] idx;
        idx = mem_addr[8:2];
        if (mem_we) begin
            words[idx] = mem_wdata;
            log_data.push_back(mem_wdata);
        end else begin
            // read data stays put while ack is high
            mem_rdata = words[idx];
            log_data.push_back(words[idx]);
        end
        log_we.push_back(mem_we);
        log_addr.push_back(mem_addr);
        mem_ack = 1'b1;
    endtask

    // four-phase responder, everything driven on the falling edge
    initial begin
        logic [31:0] rnd;
        int delay;
        int n;
        mem_ack = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req && !mem_ack) begin
                // slow ack, 0 to 5 cycles
                rnd = $random(seed);
                delay = int'(rnd % 32'd6);
                repeat (delay) @(negedge clk);
                serve();
                // hold ack until the master drops req
                n = 0;
                while (mem_req && n < 100) begin
                    @(negedge clk);
                    n++;
                end
                if (mem_req) begin
                    stuck_count++;
                    $display("bus master never released mem_req after ack");
                end
                mem_ack = 1'b0;
            end
        end
    end

endmodule

// ==== testbench/tb_mips.sv ====
module tb_mips;

    logic        clk;
    logic        rst;
    logic        mem_req;
    logic        mem_ack;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        halted;

    int errors = 0;

    // bus values from the previous rising edge
    logic        prev_req = 1'b0;
    logic        prev_ack = 1'b0;
    logic        prev_we = 1'b0;
    logic [31:0] prev_addr = '0;
    logic [31:0] prev_wdata = '0;

    tb_clock i_clock (
        .clk (clk)
    );

    mips_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    tb_data_mem i_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s: expected 0x%08h, got 0x%08h", name, expected, actual);
        end
    endtask

    // handshake rules, sampled on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            // req may only fall once ack is up
            if (prev_req && !mem_req) begin
                assert (prev_ack) else begin
                    errors++;
                    $display("mem_req fell while mem_ack was still low");
                end
            end
            // no new request until ack is back down
            if (!prev_req && mem_req) begin
                assert (!prev_ack) else begin
                    errors++;
                    $display("mem_req rose while mem_ack was still high");
                end
            end
            if (prev_req && mem_req) begin
                check_value("mem_addr", prev_addr, mem_addr);
                check_value("mem_we", {31'd0, prev_we}, {31'd0, mem_we});
                check_value("mem_wdata", prev_wdata, mem_wdata);
            end
        end
        prev_req   <= mem_req;
        prev_ack   <= mem_ack;
        prev_we    <= mem_we;
        prev_addr  <= mem_addr;
        prev_wdata <= mem_wdata;
    end

    // 16 cycles of reset, req must stay low throughout
    task automatic apply_reset();
        int c;
        @(negedge clk);
        rst = 1'b1;
        for (c = 0; c < 16; c++) begin
            @(posedge clk);
            if (c > 0) begin
                check_value("mem_req", 32'd0, {31'd0, mem_req});
            end
            @(negedge clk);
        end
        rst = 1'b0;
    endtask

    task automatic run_program(input int run_no);
        int n;
        int j;
        i_mem.preload();
        apply_reset();
        check_value("mem_req", 32'd0, {31'd0, mem_req});
        check_value("halted", 32'd0, {31'd0, halted});
        // 15 loads and 14 stores
        n = 0;
        while (i_mem.log_addr.size() < 29 && n < 8000) begin
            @(negedge clk);
            n++;
        end
        if (i_mem.log_addr.size() < 29) begin
            errors++;
            $display("run %0d timed out after %0d bus transactions", run_no,
                     i_mem.log_addr.size());
        end
        // jr and its delay slot still have to retire
        n = 0;
        while (!halted && n < 200) begin
            @(negedge clk);
            n++;
        end
        assert (halted) else begin
            errors++;
            $display("run %0d: core did not halt after the last store", run_no);
        end
        // bus has to stay quiet once halted
        n = 0;
        while (n < 50) begin
            @(negedge clk);
            n++;
        end
        check_value("mem_req", 32'd0, {31'd0, mem_req});
        check_value("halted", 32'd1, {31'd0, halted});
        check_value("transaction count", 32'd29, i_mem.log_addr.size());
        if (i_mem.log_addr.size() >= 29) begin
            // loads from word 0 upward
            for (j = 0; j < 15; j++) begin
                check_value($sformatf("mem_we[%0d]", j), 32'd0, {31'd0, i_mem.log_we[j]});
                check_value($sformatf("mem_addr[%0d]", j), 32'(4 * j), i_mem.log_addr[j]);
            end
            // stores of neighbouring words anded together
            for (j = 0; j < 14; j++) begin
                check_value($sformatf("mem_we[%0d]", 15 + j), 32'd1,
                            {31'd0, i_mem.log_we[15 + j]});
                check_value($sformatf("mem_addr[%0d]", 15 + j), 32'h100 + 32'(4 * j),
                            i_mem.log_addr[15 + j]);
                check_value($sformatf("mem_wdata[%0d]", 15 + j),
                            i_mem.words[j] & i_mem.words[j + 1], i_mem.log_data[15 + j]);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        run_program(1);
        // second run on new data, registers must start from zero again
        run_program(2);
        $display("errors: %0d, bus timeouts: %0d", errors, i_mem.stuck_count);
        if (errors == 0 && i_mem.stuck_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
